//--- Makefile
TOP := sd_cmd_host_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --top-module sd_cmd_host -f sd_cmd_host.f

obj_dir/V$(TOP): sd_cmd_host.f $(wildcard src/*.sv bench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sd_cmd_host.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "Something failed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/sd_cmd_host_properties.sv
`timescale 1ns/1ps

module sd_cmd_host_properties (
	input logic clock,
	input logic reset,
	input logic busy,
	input logic command_complete,
	input logic cmd_out,
	input logic cmd_oe,
	input logic rx_start,
	input logic rx_done,
	input logic rx_timed_out
);
	import sd_line_pkg::*;

	logic [7:0] oe_cycles;
	logic awaiting;

	// cycles of the current cmd_oe burst seen so far
	always_ff @(posedge clock)
	begin
		if (reset)
			oe_cycles <= '0;
		else if (!cmd_oe)
			oe_cycles <= '0;
		else
			oe_cycles <= oe_cycles + 1'b1;
	end

	// response pending from receiver arm to its done or timeout
	always_ff @(posedge clock)
	begin
		if (reset)
			awaiting <= 1'b0;
		else if (rx_start)
			awaiting <= 1'b1;
		else if (rx_done || rx_timed_out)
			awaiting <= 1'b0;
	end

	oe_length: assert property (@(posedge clock) disable iff (reset)
		$fell(cmd_oe) |-> oe_cycles == CMD_FRAME_BITS)
		else $error("cmd_oe burst ended after %0d cycles", oe_cycles);

	oe_bounded: assert property (@(posedge clock) disable iff (reset)
		cmd_oe |-> oe_cycles < CMD_FRAME_BITS)
		else $error("cmd_oe stayed high past a full frame");

	start_bit: assert property (@(posedge clock) disable iff (reset)
		$rose(cmd_oe) |-> !cmd_out)
		else $error("first command bit is not a start bit");

	end_bit: assert property (@(posedge clock) disable iff (reset)
		(cmd_oe && oe_cycles == CMD_FRAME_BITS - 1) |-> cmd_out)
		else $error("last command bit is not an end bit");

	// completion only closes a command that was already in progress
	complete_after_busy: assert property (@(posedge clock) disable iff (reset)
		command_complete |-> $past(busy))
		else $error("command_complete without a command in progress");

	busy_falls: assert property (@(posedge clock) disable iff (reset)
		command_complete |=> !busy)
		else $error("busy still high after command_complete");

	quiet_while_pending: assert property (@(posedge clock) disable iff (reset)
		awaiting |-> !cmd_oe)
		else $error("cmd_oe rose while a response was pending");

endmodule

bind sd_cmd_host sd_cmd_host_properties u_properties (
	.clock(clock),
	.reset(reset),
	.busy(busy),
	.command_complete(command_complete),
	.cmd_out(cmd_out),
	.cmd_oe(cmd_oe),
	.rx_start(rx_start),
	.rx_done(rx_done),
	.rx_timed_out(rx_timed_out)
);

//--- bench/sd_cmd_host_tb.sv
`timescale 1ns/1ps

module sd_cmd_host_tb;
	import sd_cmd_pkg::*;
	import sd_line_pkg::*;

	localparam logic [31:0] SEED = 32'd83184;
	localparam int IDLE_LIMIT = 400;
	localparam int START_LIMIT = 20;
	localparam int RESPONSE_TIMEOUT = 64;
	localparam int SILENT_TIMEOUT = 20;
	localparam int RESPONSE_GAP = 3;

	// what the card model does after a command
	localparam int CARD_QUIET = 0;
	localparam int CARD_SHORT = 1;
	localparam int CARD_R3 = 2;
	localparam int CARD_LONG = 3;

	logic clock;
	logic reset;
	logic new_command;
	logic [CMD_INDEX_W-1:0] cmd_index;
	logic [CMD_ARG_W-1:0] cmd_argument;
	logic [TIMEOUT_W-1:0] timeout_cycles;
	logic busy;
	logic command_complete;
	logic [RESP_W-1:0] response;
	logic command_timeout;
	logic command_index_error;
	logic crc_error;
	logic cmd_in;
	logic cmd_out;
	logic cmd_oe;

	logic [31:0] lcg_state;
	int error_count;
	int test_count;
	int tests_failed;

	sd_cmd_host dut (
		.clock(clock),
		.reset(reset),
		.new_command(new_command),
		.cmd_index(cmd_index),
		.cmd_argument(cmd_argument),
		.timeout_cycles(timeout_cycles),
		.busy(busy),
		.command_complete(command_complete),
		.response(response),
		.command_timeout(command_timeout),
		.command_index_error(command_index_error),
		.crc_error(crc_error),
		.cmd_in(cmd_in),
		.cmd_out(cmd_out),
		.cmd_oe(cmd_oe)
	);

	always #50 clock = ~clock;

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// x^7 + x^3 + 1 over the low count bits taken msb first
	function automatic logic [6:0] crc7_of(input logic [135:0] bits, input int count);
		logic [6:0] crc;
		logic feedback;
		crc = '0;
		for (int i = count - 1; i >= 0; i--)
		begin
			feedback = bits[i] ^ crc[6];
			crc = {crc[5:0], 1'b0};
			if (feedback)
				crc = crc ^ 7'h09;
		end
		return crc;
	endfunction

	task automatic check_equal(input string name, input logic [135:0] expected,
		input logic [135:0] actual);
		assert (actual === expected)
		else
		begin
			error_count++;
			$display("Mismatch at %0t: %s expected %0h, actual %0h", $time, name, expected,
				actual);
		end
	endtask

	task automatic report_failure(input string text);
		error_count++;
		$display("Error at %0t: %s", $time, text);
	endtask

	task automatic wait_idle();
		int cycles;
		cycles = 0;
		while (busy && cycles < IDLE_LIMIT)
		begin
			@(negedge clock);
			cycles++;
		end
		if (busy)
			report_failure("controller stayed busy and never returned to idle");
	endtask

	task automatic send_command(input logic [5:0] index, input logic [31:0] argument,
		input int timeout);
		wait_idle();
		@(posedge clock);
		new_command <= 1'b1;
		cmd_index <= index;
		cmd_argument <= argument;
		timeout_cycles <= TIMEOUT_W'(timeout);
		@(posedge clock);
		new_command <= 1'b0;
	endtask

	// a second request while the response is pending must be dropped
	task automatic request_while_busy();
		@(posedge clock);
		new_command <= 1'b1;
		@(posedge clock);
		new_command <= 1'b0;
	endtask

	// card side capture of the 48 command bits
	task automatic capture_frame(output logic [47:0] frame);
		int cycles;
		cycles = 0;
		frame = '0;
		@(negedge clock);
		while (!cmd_oe && cycles < START_LIMIT)
		begin
			@(negedge clock);
			cycles++;
		end
		if (!cmd_oe)
			report_failure("cmd_oe never rose after new_command");
		else
		begin
			for (int i = 0; i < CMD_FRAME_BITS; i++)
			begin
				if (!cmd_oe)
					report_failure("cmd_oe dropped in the middle of a command frame");
				frame = {frame[46:0], cmd_out};
				@(negedge clock);
			end
		end
	endtask

	task automatic drive_response(input logic [135:0] bits, input int count);
		repeat (RESPONSE_GAP) @(posedge clock);
		for (int i = count - 1; i >= 0; i--)
		begin
			cmd_in <= bits[i];
			@(posedge clock);
		end
		cmd_in <= LINE_IDLE;
	endtask

	task automatic wait_complete(input int limit);
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge clock);
			cycles++;
		end
		while (!command_complete && cycles < limit);
		if (!command_complete)
			report_failure($sformatf("command_complete missing after %0d cycles", limit));
	endtask

	task automatic exercise(input string name, input logic [5:0] index, input int card_mode,
		input logic [5:0] reply_index, input logic corrupt_crc, input logic expect_timeout,
		input logic expect_index_error, input logic expect_crc_error);
		logic [31:0] argument;
		logic [31:0] short_payload;
		logic [127:0] long_random;
		logic [47:0] frame;
		logic [47:0] expected_frame;
		logic [135:0] reply;
		logic [RESP_W-1:0] expected_response;
		int reply_bits;
		int timeout;
		int errors_before;
		errors_before = error_count;
		argument = next_random();
		short_payload = next_random();
		long_random = {next_random(), next_random(), next_random(), next_random()};
		timeout = expect_timeout ? SILENT_TIMEOUT : RESPONSE_TIMEOUT;
		reply = '0;
		reply_bits = 0;
		expected_response = '0;
		if (card_mode == CARD_SHORT || card_mode == CARD_R3)
		begin
			reply_bits = CMD_FRAME_BITS;
			reply[47:8] = {2'b00, reply_index, short_payload};
			reply[7:1] = (card_mode == CARD_R3) ? 7'h7F : crc7_of(reply >> 8, 40);
			reply[0] = 1'b1;
			expected_response = {96'h0, short_payload};
		end
		else if (card_mode == CARD_LONG)
		begin
			reply_bits = LONG_FRAME_BITS;
			reply[135:128] = {2'b00, 6'h3F};
			reply[127:8] = long_random[119:0];
			reply[7:1] = crc7_of(reply >> 8, 120);
			reply[0] = 1'b1;
			expected_response = {8'h00, long_random[119:0]};
		end
		if (corrupt_crc)
			reply[1] = ~reply[1];

		send_command(index, argument, timeout);
		capture_frame(frame);
		expected_frame = {2'b01, index, argument, 7'h00, 1'b1};
		expected_frame[7:1] = crc7_of(136'(expected_frame) >> 8, 40);
		check_equal("command frame", 136'(expected_frame), 136'(frame));

		// quiet card with no timeout expected means a command without response
		if (card_mode == CARD_QUIET && !expect_timeout)
			check_equal("command_complete", 136'(1), 136'(command_complete));
		else
		begin
			if (reply_bits > 0)
			begin
				request_while_busy();
				drive_response(reply, reply_bits);
			end
			wait_complete(timeout + 2);
		end

		check_equal("response", 136'(expected_response), 136'(response));
		check_equal("command_timeout", 136'(expect_timeout), 136'(command_timeout));
		check_equal("command_index_error", 136'(expect_index_error),
			136'(command_index_error));
		check_equal("crc_error", 136'(expect_crc_error), 136'(crc_error));

		test_count++;
		if (error_count == errors_before)
			$display("test %s: passed", name);
		else
		begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", name, error_count - errors_before);
		end
	endtask

	initial
	begin
		lcg_state = SEED;
		error_count = 0;
		test_count = 0;
		tests_failed = 0;
		clock = 1'b0;
		reset = 1'b1;
		new_command = 1'b0;
		cmd_index = '0;
		cmd_argument = '0;
		timeout_cycles = '0;
		cmd_in = LINE_IDLE;
		repeat (5) @(posedge clock);
		reset <= 1'b0;

		exercise("frame and short response", 6'd17, CARD_SHORT, 6'd17, 1'b0, 1'b0, 1'b0, 1'b0);
		exercise("index mismatch", 6'd17, CARD_SHORT, 6'd18, 1'b0, 1'b0, 1'b1, 1'b0);
		exercise("long response", 6'd2, CARD_LONG, 6'd0, 1'b0, 1'b0, 1'b0, 1'b0);
		exercise("r3 response", 6'd41, CARD_R3, 6'h3F, 1'b0, 1'b0, 1'b0, 1'b0);
		exercise("no response", 6'd0, CARD_QUIET, 6'd0, 1'b0, 1'b0, 1'b0, 1'b0);
		exercise("crc error", 6'd17, CARD_SHORT, 6'd17, 1'b1, 1'b0, 1'b0, 1'b1);
		exercise("silent card", 6'd17, CARD_QUIET, 6'd0, 1'b0, 1'b1, 1'b0, 1'b0);

		$display("%0d tests run, %0d failed, %0d errors", test_count, tests_failed,
			error_count);
		if (error_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- sd_cmd_host.f
src/sd_cmd_pkg.sv
src/sd_line_pkg.sv
src/sd_crc7.sv
src/sd_cmd_serializer.sv
src/sd_cmd_deserializer.sv
src/sd_cmd_controller.sv
src/sd_cmd_host.sv
bench/sd_cmd_host_properties.sv
bench/sd_cmd_host_tb.sv

//--- src/sd_cmd_controller.sv
`timescale 1ns/1ps

module sd_cmd_controller (
	input logic clock,
	input logic reset,
	input logic new_command,
	input logic [sd_cmd_pkg::CMD_INDEX_W-1:0] cmd_index,
	input logic [sd_cmd_pkg::CMD_ARG_W-1:0] cmd_argument,
	input logic [sd_cmd_pkg::TIMEOUT_W-1:0] timeout_cycles,
	output logic busy,
	output logic command_complete,
	output logic [sd_cmd_pkg::RESP_W-1:0] response,
	output logic command_timeout,
	output logic command_index_error,
	output logic crc_error,
	output logic tx_start,
	output logic [sd_cmd_pkg::CMD_BODY_W-1:0] tx_body,
	output logic rx_start,
	output sd_cmd_pkg::resp_kind_t rx_kind,
	output logic rx_check_crc,
	output logic [sd_cmd_pkg::TIMEOUT_W-1:0] rx_timeout,
	input logic tx_done,
	input logic rx_done,
	input logic rx_timed_out,
	input logic [sd_line_pkg::LONG_FRAME_BITS-1:0] rx_frame,
	input logic rx_crc_error
);
	import sd_cmd_pkg::*;
	import sd_line_pkg::*;

	typedef enum logic [1:0]
	{
		CTL_IDLE,
		CTL_SEND,
		CTL_AWAIT,
		CTL_FINISH
	} ctl_state_t;

	ctl_state_t state;
	resp_kind_t kind_q;
	logic [CMD_INDEX_W-1:0] index_q;
	logic [CMD_ARG_W-1:0] argument_q;
	logic [TIMEOUT_W-1:0] timeout_q;
	logic accept;
	logic index_mismatch;
	logic [RESP_W-1:0] payload;

	function automatic resp_kind_t kind_of_index(input logic [CMD_INDEX_W-1:0] index);
		resp_kind_t kind;
		kind = RESP_SHORT;
		if (index == CMD_IDX_GO_IDLE || index == CMD_IDX_SET_DSR ||
			index == CMD_IDX_GO_INACTIVE)
			kind = RESP_NONE;
		else if (index == CMD_IDX_ALL_SEND_CID || index == CMD_IDX_SEND_CSD ||
			index == CMD_IDX_SEND_CID)
			kind = RESP_LONG;
		return kind;
	endfunction

	// requests while busy are dropped here
	assign accept = (state == CTL_IDLE) && new_command;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= CTL_IDLE;
			kind_q <= RESP_NONE;
			tx_start <= 1'b0;
			command_timeout <= 1'b0;
			command_index_error <= 1'b0;
			crc_error <= 1'b0;
		end
		else
		begin
			tx_start <= 1'b0;
			case (state)
				CTL_IDLE:
				begin
					if (accept)
					begin
						state <= CTL_SEND;
						kind_q <= kind_of_index(cmd_index);
						tx_start <= 1'b1;
						command_timeout <= 1'b0;
						command_index_error <= 1'b0;
						crc_error <= 1'b0;
					end
				end
				CTL_SEND:
				begin
					if (tx_done)
						state <= (kind_q == RESP_NONE) ? CTL_FINISH : CTL_AWAIT;
				end
				CTL_AWAIT:
				begin
					if (rx_timed_out)
					begin
						state <= CTL_FINISH;
						command_timeout <= 1'b1;
					end
					else if (rx_done)
					begin
						state <= CTL_FINISH;
						crc_error <= rx_crc_error;
						command_index_error <= index_mismatch;
					end
				end
				default:
					state <= CTL_IDLE;
			endcase
		end
	end

	// long frames map 127..8 to 119..0 and short frames map the argument field to 31..0
	assign payload = (kind_q == RESP_LONG) ?
		RESP_W'(rx_frame[LONG_CRC_START:CRC_COVER_LSB]) :
		RESP_W'(rx_frame[SHORT_ARG_MSB:CRC_COVER_LSB]);

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			index_q <= cmd_index;
			argument_q <= cmd_argument;
			timeout_q <= timeout_cycles;
			response <= '0;
		end
		else if (state == CTL_AWAIT && rx_done)
			response <= payload;
	end

	// R3 echoes 111111 in place of the index
	assign index_mismatch = (kind_q == RESP_SHORT) && (index_q != CMD_IDX_R3) &&
		(rx_frame[SHORT_IDX_MSB:SHORT_IDX_LSB] != index_q);

	assign busy = (state != CTL_IDLE);
	assign command_complete = (state == CTL_FINISH);

	assign tx_body = {CMD_PREFIX, index_q, argument_q};

	// receiver is armed on the last command bit
	assign rx_start = (state == CTL_SEND) && tx_done && (kind_q != RESP_NONE);
	assign rx_kind = kind_q;
	assign rx_check_crc = (index_q != CMD_IDX_R3);
	assign rx_timeout = timeout_q;

endmodule

//--- src/sd_cmd_deserializer.sv
`timescale 1ns/1ps

module sd_cmd_deserializer (
	input logic clock,
	input logic reset,
	input logic rx_start,
	input sd_cmd_pkg::resp_kind_t rx_kind,
	input logic rx_check_crc,
	input logic [sd_cmd_pkg::TIMEOUT_W-1:0] rx_timeout,
	input logic cmd_in,
	output logic rx_done,
	output logic rx_timed_out,
	output logic [sd_line_pkg::LONG_FRAME_BITS-1:0] rx_frame,
	output logic rx_crc_error
);
	import sd_cmd_pkg::*;
	import sd_line_pkg::*;

	typedef enum logic [1:0]
	{
		RX_IDLE,
		RX_WAIT,
		RX_SHIFT,
		RX_REPORT
	} rx_state_t;

	rx_state_t state;
	logic [TIMEOUT_W-1:0] wait_count;
	logic [TIMEOUT_W-1:0] wait_next;
	logic [BIT_COUNT_W-1:0] bit_count;
	logic [BIT_COUNT_W-1:0] last_bit;
	logic [BIT_COUNT_W-1:0] crc_first;
	logic [BIT_COUNT_W-1:0] crc_last;
	logic long_frame;
	logic start_seen;
	logic crc_enable;
	logic [CRC7_W-1:0] crc;

	assign long_frame = (rx_kind == RESP_LONG);
	assign last_bit = long_frame ? BIT_COUNT_W'(LONG_FRAME_BITS - 1) :
		BIT_COUNT_W'(CMD_FRAME_BITS - 1);

	// bit numbers count from the start bit, which is number 0
	assign crc_first = long_frame ? BIT_COUNT_W'(LONG_FRAME_BITS - 1 - LONG_CRC_START) : '0;
	assign crc_last = last_bit - BIT_COUNT_W'(CRC_COVER_LSB);

	assign wait_next = wait_count + 1'b1;
	assign start_seen = (state == RX_WAIT) && !cmd_in;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= RX_IDLE;
			wait_count <= '0;
			bit_count <= '0;
			rx_timed_out <= 1'b0;
		end
		else
		begin
			rx_timed_out <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					if (rx_start)
					begin
						state <= RX_WAIT;
						wait_count <= '0;
					end
				end
				RX_WAIT:
				begin
					if (!cmd_in)
					begin
						state <= RX_SHIFT;
						bit_count <= BIT_COUNT_W'(1);
					end
					else if (wait_next >= rx_timeout)
					begin
						state <= RX_IDLE;
						rx_timed_out <= 1'b1;
					end
					else
						wait_count <= wait_next;
				end
				RX_SHIFT:
				begin
					bit_count <= bit_count + 1'b1;
					// end bit arrives on this cycle
					if (bit_count == last_bit)
						state <= RX_REPORT;
				end
				default:
					state <= RX_IDLE;
			endcase
		end
	end

	// frame lands right-aligned, short frames leave the top bits zero
	always_ff @(posedge clock)
	begin
		if (state == RX_IDLE && rx_start)
			rx_frame <= '0;
		else if (start_seen || state == RX_SHIFT)
			rx_frame <= {rx_frame[LONG_FRAME_BITS-2:0], cmd_in};
	end

	// start bit is covered only in short frames
	assign crc_enable = (start_seen && !long_frame) ||
		(state == RX_SHIFT && bit_count >= crc_first && bit_count <= crc_last);

	sd_crc7 u_crc7 (
		.clock(clock),
		.reset(reset),
		.clear(rx_start),
		.enable(crc_enable),
		.data(cmd_in),
		.crc(crc)
	);

	assign rx_done = (state == RX_REPORT);
	assign rx_crc_error = rx_done && rx_check_crc &&
		(crc != rx_frame[CRC_FIELD_LSB +: CRC7_W]);

endmodule

//--- src/sd_cmd_host.sv
`timescale 1ns/1ps

module sd_cmd_host (
	input logic clock,
	input logic reset,
	input logic new_command,
	input logic [sd_cmd_pkg::CMD_INDEX_W-1:0] cmd_index,
	input logic [sd_cmd_pkg::CMD_ARG_W-1:0] cmd_argument,
	input logic [sd_cmd_pkg::TIMEOUT_W-1:0] timeout_cycles,
	output logic busy,
	output logic command_complete,
	output logic [sd_cmd_pkg::RESP_W-1:0] response,
	output logic command_timeout,
	output logic command_index_error,
	output logic crc_error,
	input logic cmd_in,
	output logic cmd_out,
	output logic cmd_oe
);
	import sd_cmd_pkg::*;
	import sd_line_pkg::*;

	logic tx_start;
	logic [CMD_BODY_W-1:0] tx_body;
	logic tx_done;
	logic rx_start;
	resp_kind_t rx_kind;
	logic rx_check_crc;
	logic [TIMEOUT_W-1:0] rx_timeout;
	logic rx_done;
	logic rx_timed_out;
	logic [LONG_FRAME_BITS-1:0] rx_frame;
	logic rx_crc_error;

	sd_cmd_controller u_controller (
		.clock(clock),
		.reset(reset),
		.new_command(new_command),
		.cmd_index(cmd_index),
		.cmd_argument(cmd_argument),
		.timeout_cycles(timeout_cycles),
		.busy(busy),
		.command_complete(command_complete),
		.response(response),
		.command_timeout(command_timeout),
		.command_index_error(command_index_error),
		.crc_error(crc_error),
		.tx_start(tx_start),
		.tx_body(tx_body),
		.rx_start(rx_start),
		.rx_kind(rx_kind),
		.rx_check_crc(rx_check_crc),
		.rx_timeout(rx_timeout),
		.tx_done(tx_done),
		.rx_done(rx_done),
		.rx_timed_out(rx_timed_out),
		.rx_frame(rx_frame),
		.rx_crc_error(rx_crc_error)
	);

	sd_cmd_serializer u_serializer (
		.clock(clock),
		.reset(reset),
		.tx_start(tx_start),
		.tx_body(tx_body),
		.tx_done(tx_done),
		.cmd_out(cmd_out),
		.cmd_oe(cmd_oe)
	);

	sd_cmd_deserializer u_deserializer (
		.clock(clock),
		.reset(reset),
		.rx_start(rx_start),
		.rx_kind(rx_kind),
		.rx_check_crc(rx_check_crc),
		.rx_timeout(rx_timeout),
		.cmd_in(cmd_in),
		.rx_done(rx_done),
		.rx_timed_out(rx_timed_out),
		.rx_frame(rx_frame),
		.rx_crc_error(rx_crc_error)
	);

endmodule

//--- src/sd_cmd_pkg.sv
package sd_cmd_pkg;

	// host-side field widths
	localparam int CMD_INDEX_W = 6;
	localparam int CMD_ARG_W = 32;
	localparam int TIMEOUT_W = 32;

	// start, direction, index and argument
	localparam int CMD_BODY_W = 40;

	// response register as the host sees it
	localparam int RESP_W = 128;

	// start bit 0 followed by the host direction bit
	localparam logic [1:0] CMD_PREFIX = 2'b01;

	// R3 carries no valid CRC and no echoed index
	localparam logic [CMD_INDEX_W-1:0] CMD_IDX_R3 = 6'd41;

	// commands without a response
	localparam logic [CMD_INDEX_W-1:0] CMD_IDX_GO_IDLE = 6'd0;
	localparam logic [CMD_INDEX_W-1:0] CMD_IDX_SET_DSR = 6'd4;
	localparam logic [CMD_INDEX_W-1:0] CMD_IDX_GO_INACTIVE = 6'd15;

	// commands with a 136-bit response
	localparam logic [CMD_INDEX_W-1:0] CMD_IDX_ALL_SEND_CID = 6'd2;
	localparam logic [CMD_INDEX_W-1:0] CMD_IDX_SEND_CSD = 6'd9;
	localparam logic [CMD_INDEX_W-1:0] CMD_IDX_SEND_CID = 6'd10;

	typedef enum logic [1:0]
	{
		RESP_NONE,
		RESP_SHORT,
		RESP_LONG
	} resp_kind_t;

endpackage

//--- src/sd_cmd_serializer.sv
`timescale 1ns/1ps

module sd_cmd_serializer (
	input logic clock,
	input logic reset,
	input logic tx_start,
	input logic [sd_cmd_pkg::CMD_BODY_W-1:0] tx_body,
	output logic tx_done,
	output logic cmd_out,
	output logic cmd_oe
);
	import sd_cmd_pkg::*;
	import sd_line_pkg::*;

	logic [CMD_BODY_W-1:0] shift_reg;
	logic [BIT_COUNT_W-1:0] bit_count;
	logic [CRC7_W-1:0] crc;
	logic crc_clear;
	logic crc_enable;

	// cmd_oe doubles as the busy flag of the engine
	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			cmd_oe <= 1'b0;
			bit_count <= '0;
		end
		else if (!cmd_oe)
		begin
			if (tx_start)
			begin
				cmd_oe <= 1'b1;
				bit_count <= '0;
			end
		end
		else
		begin
			bit_count <= bit_count + 1'b1;
			if (tx_done)
				cmd_oe <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (tx_start && !cmd_oe)
			shift_reg <= tx_body;
		else if (cmd_oe)
			shift_reg <= {shift_reg[CMD_BODY_W-2:0], 1'b0};
	end

	// body bits, then CRC bits from the top of the LFSR, then the end bit
	always_comb
	begin
		if (!cmd_oe)
			cmd_out = LINE_IDLE;
		else if (bit_count < CMD_BODY_W)
			cmd_out = shift_reg[CMD_BODY_W-1];
		else if (bit_count < CMD_FRAME_BITS - 1)
			cmd_out = crc[CRC7_W-1];
		else
			cmd_out = 1'b1;
	end

	assign tx_done = cmd_oe && (bit_count == BIT_COUNT_W'(CMD_FRAME_BITS - 1));

	// feeding the CRC its own MSB during the CRC field turns it into a plain shifter
	assign crc_clear = tx_start && !cmd_oe;
	assign crc_enable = cmd_oe && !tx_done;

	sd_crc7 u_crc7 (
		.clock(clock),
		.reset(reset),
		.clear(crc_clear),
		.enable(crc_enable),
		.data(cmd_out),
		.crc(crc)
	);

endmodule

//--- src/sd_crc7.sv
`timescale 1ns/1ps

module sd_crc7 (
	input logic clock,
	input logic reset,
	input logic clear,
	input logic enable,
	input logic data,
	output logic [sd_line_pkg::CRC7_W-1:0] crc
);
	import sd_line_pkg::*;

	logic feedback;

	// serial form with the register MSB leaving first
	assign feedback = data ^ crc[CRC7_W-1];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			crc <= '0;
		end
		else if (clear)
		begin
			crc <= '0;
		end
		else if (enable)
		begin
			crc <= {crc[CRC7_W-2:0], 1'b0} ^ (feedback ? CRC7_POLY[CRC7_W-1:0] : '0);
		end
	end

endmodule

//--- src/sd_line_pkg.sv
package sd_line_pkg;

	// frame lengths on the CMD line
	localparam int CMD_FRAME_BITS = 48;
	localparam int LONG_FRAME_BITS = 136;

	// wide enough to count a long frame
	localparam int BIT_COUNT_W = 8;

	// x^7 + x^3 + 1 with the x^7 term implied by the shift
	localparam int CRC7_W = 7;
	localparam logic [7:0] CRC7_POLY = 8'h89;

	localparam logic LINE_IDLE = 1'b1;

	// CRC of a long response covers bits 127 down to 8 only
	localparam int LONG_CRC_START = 127;

	// lowest frame bit covered by the CRC in both frame forms
	localparam int CRC_COVER_LSB = 8;

	// CRC field sits just above the end bit
	localparam int CRC_FIELD_LSB = 1;

	// short response layout
	localparam int SHORT_IDX_MSB = 45;
	localparam int SHORT_IDX_LSB = 40;
	localparam int SHORT_ARG_MSB = 39;

endpackage
